// File: Bender.yml
package:
  name: uno_computer_player

sources:
  - include_dirs:
      - include
    files:
      - rtl/uno_card_pkg.sv
      - rtl/uno_turn_pkg.sv
      - rtl/uno_hand_store.sv
      - rtl/uno_play_selector.sv
      - rtl/uno_turn_ctrl.sv
      - rtl/uno_computer_player.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/uno_player_properties.sv
      - dv/tb_uno_computer_player.sv

// File: compile.f
+incdir+include
rtl/uno_card_pkg.sv
rtl/uno_turn_pkg.sv
rtl/uno_hand_store.sv
rtl/uno_play_selector.sv
rtl/uno_turn_ctrl.sv
rtl/uno_computer_player.sv
dv/uno_player_properties.sv
dv/tb_uno_computer_player.sv

// File: dv/tb_uno_computer_player.sv
`timescale 1ns/1ps
`include "uno_config.svh"

module tb_uno_computer_player;

    typedef enum logic [1:0] {req_init, req_start, req_two, req_four} req_e;

    typedef struct packed {
        req_e                          kind;
        logic [2:0]                    n_cards;
        uno_card_pkg::uno_card_t [6:0] cards;     // cards[0] is dealt first
        uno_card_pkg::uno_card_t       prev;
        logic [3:0]                    ready_delay;
        logic                          exp_play;  // low when a draw is expected
        logic                          rand_gap;
    } row_t;

    localparam logic [3:0] wild_value  = 4'd13;
    localparam logic [3:0] wild4_value = 4'd14;

    logic                    i_clk = 1'b0;
    logic                    i_rst_n;
    logic                    i_init;
    logic                    i_start;
    logic                    i_draw_two;
    logic                    i_draw_four;
    uno_card_pkg::uno_card_t i_prev_card;
    logic                    i_card_valid;
    uno_card_pkg::uno_card_t i_card;
    logic                    i_play_ready;
    logic                    o_card_ready;
    logic                    o_draw_req;
    logic                    o_play_valid;
    uno_card_pkg::uno_card_t o_play_card;
    logic                    o_turn_done;

    row_t   rows[$];
    int     hand_cnt [4][`UNO_NUM_VALUES];  // count model of the hand
    int     wild_cnt;
    int     wild4_cnt;
    int     errors;
    int     checks;
    integer seed = 32'ha0e5_53b5;
    logic   table_built = 1'b0;

    uno_computer_player i_dut (.*);

    always #4 i_clk = ~i_clk;

    function automatic int bounded(input int x);
        return (x > `UNO_COUNT_MAX) ? `UNO_COUNT_MAX : x;
    endfunction

    task automatic model_update(input uno_card_pkg::uno_card_t card, input int delta);
        if (card.value == wild_value) begin
            wild_cnt = bounded(wild_cnt + delta);
        end else if (card.value == wild4_value) begin
            wild4_cnt = bounded(wild4_cnt + delta);
        end else begin
            hand_cnt[card.color][card.value] = bounded(hand_cnt[card.color][card.value] + delta);
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // {found, card} by the selection rule, from the model
    function automatic logic [6:0] predict(input uno_card_pkg::uno_card_t prev);
        int totals [4];
        int best;
        if (prev.value < `UNO_NUM_VALUES) begin
            for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
                if (hand_cnt[prev.color][v] != 0) return {1'b1, prev.color, 4'(v)};
            end
            for (int c = 0; c < 4; c++) begin
                if (hand_cnt[c][prev.value] != 0) return {1'b1, 2'(c), prev.value};
            end
        end
        best = 0;
        for (int c = 0; c < 4; c++) begin
            totals[c] = 0;
            for (int v = 0; v < `UNO_NUM_VALUES; v++) totals[c] += hand_cnt[c][v];
            if (totals[c] > totals[best]) best = c;  // ties stay on the lower color
        end
        if (wild_cnt != 0) return {1'b1, 2'(best), wild_value};
        if (wild4_cnt != 0) return {1'b1, 2'(best), wild4_value};
        return '0;
    endfunction

    task automatic push_row(input req_e kind, input int n, input logic [41:0] cards,
                            input logic [5:0] prev, input int delay, input logic exp_play,
                            input logic gap);
        row_t r;
        r.kind        = kind;
        r.n_cards     = 3'(n);
        r.cards       = cards;
        r.prev        = prev;
        r.ready_delay = 4'(delay);
        r.exp_play    = exp_play;
        r.rand_gap    = gap;
        rows.push_back(r);
    endtask

    task automatic deal_cards(input row_t r);
        int gap;
        for (int i = 0; i < r.n_cards; i++) begin
            i_card_valid = 1'b0;
            gap = r.rand_gap ? ($random(seed) & 3) : 0;
            repeat (gap) @(negedge i_clk);
            i_card_valid = 1'b1;
            i_card       = r.cards[i];
            while (!o_card_ready) @(negedge i_clk);
            @(negedge i_clk);  // taken on the rising edge in between
            model_update(r.cards[i], 1);
        end
        i_card_valid = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        logic [6:0] exp;
        int         waited;
        i_prev_card = r.prev;
        i_init      = (r.kind == req_init);
        i_start     = (r.kind != req_init);
        i_draw_two  = (r.kind == req_two);
        i_draw_four = (r.kind == req_four);
        @(negedge i_clk);
        i_init      = 1'b0;
        i_start     = 1'b0;
        i_draw_two  = 1'b0;
        i_draw_four = 1'b0;
        if (r.kind != req_start) begin
            deal_cards(r);
            compare_value("o_card_ready", o_card_ready, 1'b0);  // no extra transfer
            if (r.kind == req_init) begin
                @(negedge i_clk);
                compare_value("o_turn_done", o_turn_done, 1'b0);
                return;
            end
        end
        exp = predict(r.prev);
        compare_value("model_found", exp[6], r.exp_play);
        waited = 0;
        while (!o_play_valid && !o_draw_req) begin
            @(negedge i_clk);
            waited++;
        end
        compare_value("offer_latency", waited, 1);
        compare_value("o_play_valid", o_play_valid, r.exp_play);
        compare_value("o_draw_req", o_draw_req, !r.exp_play);
        if (r.exp_play) begin
            compare_value("o_play_card", o_play_card, exp[5:0]);
            repeat (r.ready_delay) begin
                @(negedge i_clk);
                compare_value("o_play_valid", o_play_valid, 1'b1);
                compare_value("o_play_card", o_play_card, exp[5:0]);
            end
            i_play_ready = 1'b1;
            @(negedge i_clk);
            i_play_ready = 1'b0;
            model_update(exp[5:0], -1);
        end else begin
            deal_cards(r);
        end
        compare_value("o_turn_done", o_turn_done, 1'b1);
        compare_value("o_play_valid", o_play_valid, 1'b0);
        @(negedge i_clk);
        compare_value("o_turn_done", o_turn_done, 1'b0);
    endtask

    initial begin
        wait (table_built);
        repeat (rows.size() * 200) @(posedge i_clk);
        $display("timeout: the turns did not finish within %0d cycles", rows.size() * 200);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        i_rst_n      = 1'b0;
        i_init       = 1'b0;
        i_start      = 1'b0;
        i_draw_two   = 1'b0;
        i_draw_four  = 1'b0;
        i_prev_card  = '0;
        i_card_valid = 1'b0;
        i_card       = '0;
        i_play_ready = 1'b0;
        push_row(req_start, 1, 42'h09, 6'h05, 0, 1'b0, 1'b0);  // empty hand draws
        push_row(req_init, 7, {6'h0E, 6'h0D, 6'h32, 6'h24, 6'h14, 6'h07, 6'h03}, 6'h00, 0,
                 1'b0, 1'b1);
        push_row(req_start, 0, '0, 6'h0C, 0, 1'b1, 1'b0);
        push_row(req_start, 0, '0, 6'h3B, 3, 1'b1, 1'b0);
        push_row(req_start, 0, '0, 6'h34, 0, 1'b1, 1'b0);      // blue missing, value match
        push_row(req_start, 0, '0, 6'h2D, 1, 1'b1, 1'b0);
        push_row(req_two, 2, {6'h37, 6'h27}, 6'h11, 2, 1'b1, 1'b0);
        push_row(req_start, 1, 42'h16, 6'h10, 0, 1'b0, 1'b0);
        push_row(req_start, 0, '0, 6'h1C, 0, 1'b1, 1'b0);      // drawn card is played
        push_row(req_four, 4, {6'h35, 6'h12, 6'h0D, 6'h31}, 6'h3E, 4, 1'b1, 1'b1);
        push_row(req_start, 0, '0, 6'h27, 0, 1'b1, 1'b0);
        push_row(req_start, 0, '0, 6'h01, 0, 1'b1, 1'b0);
        table_built = 1'b1;
        repeat (3) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        compare_value("o_card_ready", o_card_ready, 1'b0);
        compare_value("o_draw_req", o_draw_req, 1'b0);
        compare_value("o_play_valid", o_play_valid, 1'b0);
        compare_value("o_turn_done", o_turn_done, 1'b0);
        foreach (rows[k]) run_row(rows[k]);
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_dut.u_props.fail_count);
        if (errors == 0 && i_dut.u_props.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: dv/uno_player_properties.sv
`timescale 1ns/1ps
`include "uno_config.svh"

module uno_player_properties (
    input logic                    i_clk,
    input logic                    i_rst_n,
    input logic                    i_card_ready,
    input logic                    i_draw_req,
    input logic                    i_play_valid,
    input logic                    i_play_ready,
    input uno_card_pkg::uno_card_t i_play_card,
    input logic                    i_turn_done,
    input logic                    i_remove,
    input uno_card_pkg::uno_card_t i_remove_card,
    input uno_card_pkg::uno_hand_t i_hand
);

    localparam logic [`UNO_VALUE_W-1:0] wild_value  = `UNO_WILD_CODE;
    localparam logic [`UNO_VALUE_W-1:0] wild4_value = `UNO_WILD4_CODE;

    int   fail_count = 0;
    logic slot_held;

    // count of the slot that the remove strobe names
    always_comb begin
        if (i_remove_card.value == wild_value) begin
            slot_held = i_hand.wild != '0;
        end else if (i_remove_card.value == wild4_value) begin
            slot_held = i_hand.wild4 != '0;
        end else if (int'(i_remove_card.value) < `UNO_NUM_VALUES) begin
            slot_held = i_hand.colored[i_remove_card.color][i_remove_card.value] != '0;
        end else begin
            slot_held = 1'b0;  // code 15 has no slot
        end
    end

    offer_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_play_valid && !i_play_ready |=> i_play_valid && $stable(i_play_card))
        else begin
            $error("offer dropped or changed before acceptance");
            fail_count++;
        end

    draw_or_play: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_draw_req && i_play_valid))
        else begin
            $error("draw request and play offer high together");
            fail_count++;
        end

    done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_turn_done |=> !i_turn_done)
        else begin
            $error("turn done longer than one cycle");
            fail_count++;
        end

    remove_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_remove |-> slot_held)
        else begin
            $error("card removed from an empty hand slot");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |-> !(i_card_ready || i_draw_req || i_play_valid || i_turn_done))
        else begin
            $error("control output high in reset");
            fail_count++;
        end

endmodule

bind uno_computer_player uno_player_properties u_props (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_card_ready  (o_card_ready),
    .i_draw_req    (o_draw_req),
    .i_play_valid  (o_play_valid),
    .i_play_ready  (i_play_ready),
    .i_play_card   (o_play_card),
    .i_turn_done   (o_turn_done),
    .i_remove      (remove),
    .i_remove_card (remove_card),
    .i_hand        (hand)
);

// File: include/uno_config.svh
`ifndef UNO_CONFIG_SVH
`define UNO_CONFIG_SVH

// card encoding
`define UNO_CARD_W      6
`define UNO_VALUE_W     4
`define UNO_NUM_COLORS  4
`define UNO_NUM_VALUES  13   // values 0..12 carry a color
`define UNO_WILD_CODE   13
`define UNO_WILD4_CODE  14

// hand counts, saturating
`define UNO_COUNT_W     2
`define UNO_COUNT_MAX   3

// draw runs
`define UNO_INIT_HAND   7
`define UNO_DRAW_TWO    2
`define UNO_DRAW_FOUR   4
`define UNO_DRAW_CNT_W  3

`endif

// File: rtl/uno_card_pkg.sv
`include "uno_config.svh"

package uno_card_pkg;

    typedef enum logic [1:0] {
        color_red    = 2'd0,
        color_yellow = 2'd1,
        color_green  = 2'd2,
        color_blue   = 2'd3
    } uno_color_e;

    // 6 bit card, color in the upper two bits
    typedef struct packed {
        uno_color_e                color;
        logic [`UNO_VALUE_W-1:0]   value;
    } uno_card_t;

    typedef logic [`UNO_COUNT_W-1:0] uno_count_t;

    // one count per colored card plus the two wild kinds
    typedef struct packed {
        uno_count_t                                             wild4;
        uno_count_t                                             wild;
        uno_count_t [`UNO_NUM_COLORS-1:0][`UNO_NUM_VALUES-1:0]  colored;
    } uno_hand_t;

    typedef struct packed {
        logic       found;
        uno_card_t  card;    // wild cards already carry the named color
        uno_card_t  remove;  // slot to decrement in the hand
    } uno_choice_t;

endpackage

// File: rtl/uno_computer_player.sv
`timescale 1ns/1ps

module uno_computer_player (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_init,
    input  logic                    i_start,
    input  logic                    i_draw_two,
    input  logic                    i_draw_four,
    input  uno_card_pkg::uno_card_t i_prev_card,
    input  logic                    i_card_valid,
    input  uno_card_pkg::uno_card_t i_card,
    input  logic                    i_play_ready,
    output logic                    o_card_ready,
    output logic                    o_draw_req,
    output logic                    o_play_valid,
    output uno_card_pkg::uno_card_t o_play_card,
    output logic                    o_turn_done
);

    uno_card_pkg::uno_hand_t   hand;
    uno_card_pkg::uno_choice_t choice;
    uno_card_pkg::uno_card_t   remove_card;
    logic                      add;
    logic                      remove;

    uno_hand_store u_store (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_add         (add),
        .i_add_card    (i_card),
        .i_remove      (remove),
        .i_remove_card (remove_card),
        .o_hand        (hand)
    );

    uno_play_selector u_selector (
        .i_prev_card (i_prev_card),
        .i_hand      (hand),
        .o_choice    (choice)
    );

    uno_turn_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init        (i_init),
        .i_start       (i_start),
        .i_draw_two    (i_draw_two),
        .i_draw_four   (i_draw_four),
        .i_card_valid  (i_card_valid),
        .i_card        (i_card),
        .i_play_ready  (i_play_ready),
        .i_choice      (choice),
        .o_card_ready  (o_card_ready),
        .o_draw_req    (o_draw_req),
        .o_play_valid  (o_play_valid),
        .o_play_card   (o_play_card),
        .o_turn_done   (o_turn_done),
        .o_add         (add),
        .o_remove      (remove),
        .o_remove_card (remove_card)
    );

endmodule

// File: rtl/uno_hand_store.sv
`timescale 1ns/1ps
`include "uno_config.svh"

module uno_hand_store (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_add,
    input  uno_card_pkg::uno_card_t i_add_card,
    input  logic                    i_remove,
    input  uno_card_pkg::uno_card_t i_remove_card,
    output uno_card_pkg::uno_hand_t o_hand
);

    localparam uno_card_pkg::uno_count_t count_max = `UNO_COUNT_MAX;
    localparam logic [`UNO_VALUE_W-1:0] wild_value  = `UNO_WILD_CODE;
    localparam logic [`UNO_VALUE_W-1:0] wild4_value = `UNO_WILD4_CODE;

    uno_card_pkg::uno_hand_t hand_q;
    uno_card_pkg::uno_hand_t hand_d;

    function automatic logic colored_hit(
        input uno_card_pkg::uno_card_t card,
        input int                      c,
        input int                      v
    );
        return (int'(card.color) == c) && (int'(card.value) == v);
    endfunction

    function automatic uno_card_pkg::uno_count_t next_count(
        input uno_card_pkg::uno_count_t cnt,
        input logic                     inc,
        input logic                     dec
    );
        uno_card_pkg::uno_count_t res;
        res = cnt;
        if (inc && !dec && cnt != count_max) begin
            res = cnt + 1'b1;
        end else if (dec && !inc && cnt != '0) begin
            res = cnt - 1'b1;
        end
        return res;
    endfunction

    always_comb begin
        hand_d = hand_q;
        for (int c = 0; c < `UNO_NUM_COLORS; c++) begin
            for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
                hand_d.colored[c][v] = next_count(hand_q.colored[c][v],
                                                  i_add && colored_hit(i_add_card, c, v),
                                                  i_remove && colored_hit(i_remove_card, c, v));
            end
        end
        // wild kinds are counted regardless of color
        hand_d.wild  = next_count(hand_q.wild,
                                  i_add && (i_add_card.value == wild_value),
                                  i_remove && (i_remove_card.value == wild_value));
        hand_d.wild4 = next_count(hand_q.wild4,
                                  i_add && (i_add_card.value == wild4_value),
                                  i_remove && (i_remove_card.value == wild4_value));
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hand_q <= '0;  // empty hand
        end else begin
            hand_q <= hand_d;
        end
    end

    assign o_hand = hand_q;

endmodule

// File: rtl/uno_play_selector.sv
`timescale 1ns/1ps
`include "uno_config.svh"

module uno_play_selector (
    input  uno_card_pkg::uno_card_t   i_prev_card,
    input  uno_card_pkg::uno_hand_t   i_hand,
    output uno_card_pkg::uno_choice_t o_choice
);

    localparam int total_w = $clog2(`UNO_NUM_VALUES * `UNO_COUNT_MAX + 1);
    localparam logic [`UNO_VALUE_W-1:0] wild_value  = `UNO_WILD_CODE;
    localparam logic [`UNO_VALUE_W-1:0] wild4_value = `UNO_WILD4_CODE;

    logic                      prev_colored;
    logic                      color_hit;
    logic [`UNO_VALUE_W-1:0]   color_value;
    logic                      value_hit;
    uno_card_pkg::uno_color_e  value_color;
    logic [total_w-1:0]        color_total [`UNO_NUM_COLORS];
    logic [total_w-1:0]        best_total;
    uno_card_pkg::uno_color_e  best_color;

    assign prev_colored = int'(i_prev_card.value) < `UNO_NUM_VALUES;

    // lowest value held in the previous color
    always_comb begin
        color_hit   = 1'b0;
        color_value = '0;
        for (int v = `UNO_NUM_VALUES - 1; v >= 0; v--) begin
            if (i_hand.colored[i_prev_card.color][v] != '0) begin
                color_hit   = 1'b1;
                color_value = v[`UNO_VALUE_W-1:0];
            end
        end
    end

    // same value, red first
    always_comb begin
        value_hit   = 1'b0;
        value_color = uno_card_pkg::color_red;
        for (int c = `UNO_NUM_COLORS - 1; c >= 0; c--) begin
            if (prev_colored && i_hand.colored[c][i_prev_card.value] != '0) begin
                value_hit   = 1'b1;
                value_color = uno_card_pkg::uno_color_e'(c[1:0]);
            end
        end
    end

    // color to name for a wild, strict compare keeps ties on the lower index
    always_comb begin
        for (int c = 0; c < `UNO_NUM_COLORS; c++) begin
            color_total[c] = '0;
            for (int v = 0; v < `UNO_NUM_VALUES; v++) begin
                color_total[c] = color_total[c] + total_w'(i_hand.colored[c][v]);
            end
        end
        best_color = uno_card_pkg::color_red;
        best_total = color_total[0];
        for (int c = 1; c < `UNO_NUM_COLORS; c++) begin
            if (color_total[c] > best_total) begin
                best_total = color_total[c];
                best_color = uno_card_pkg::uno_color_e'(c[1:0]);
            end
        end
    end

    always_comb begin
        o_choice.found = 1'b1;
        if (prev_colored && color_hit) begin
            o_choice.card   = '{color: i_prev_card.color, value: color_value};
            o_choice.remove = o_choice.card;
        end else if (prev_colored && value_hit) begin
            o_choice.card   = '{color: value_color, value: i_prev_card.value};
            o_choice.remove = o_choice.card;
        end else if (i_hand.wild != '0) begin
            o_choice.card   = '{color: best_color, value: wild_value};
            o_choice.remove = '{color: uno_card_pkg::color_red, value: wild_value};
        end else if (i_hand.wild4 != '0) begin
            o_choice.card   = '{color: best_color, value: wild4_value};
            o_choice.remove = '{color: uno_card_pkg::color_red, value: wild4_value};
        end else begin
            o_choice.found  = 1'b0;  // nothing playable
            o_choice.card   = i_prev_card;
            o_choice.remove = i_prev_card;
        end
    end

endmodule

// File: rtl/uno_turn_ctrl.sv
`timescale 1ns/1ps
`include "uno_config.svh"

module uno_turn_ctrl (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_init,
    input  logic                      i_start,
    input  logic                      i_draw_two,
    input  logic                      i_draw_four,
    input  logic                      i_card_valid,
    input  uno_card_pkg::uno_card_t   i_card,
    input  logic                      i_play_ready,
    input  uno_card_pkg::uno_choice_t i_choice,
    output logic                      o_card_ready,
    output logic                      o_draw_req,
    output logic                      o_play_valid,
    output uno_card_pkg::uno_card_t   o_play_card,
    output logic                      o_turn_done,
    output logic                      o_add,
    output logic                      o_remove,
    output uno_card_pkg::uno_card_t   o_remove_card
);

    localparam logic [`UNO_DRAW_CNT_W-1:0] cnt_init  = `UNO_INIT_HAND;
    localparam logic [`UNO_DRAW_CNT_W-1:0] cnt_two   = `UNO_DRAW_TWO;
    localparam logic [`UNO_DRAW_CNT_W-1:0] cnt_four  = `UNO_DRAW_FOUR;
    localparam logic [`UNO_VALUE_W-1:0]    max_value = `UNO_WILD4_CODE;

    uno_turn_pkg::uno_turn_state_e  state_q, state_d;
    uno_turn_pkg::uno_draw_reason_e reason_q, reason_d;
    logic [`UNO_DRAW_CNT_W-1:0]     draw_cnt_q, draw_cnt_d;
    logic                           done_q, done_d;
    uno_card_pkg::uno_card_t        play_card_q;
    logic                           transfer;
    logic                           take_choice;

    assign o_card_ready = (state_q == uno_turn_pkg::st_draw) ||
                          (state_q == uno_turn_pkg::st_no_card);
    assign o_draw_req   = state_q == uno_turn_pkg::st_no_card;
    assign o_play_valid = state_q == uno_turn_pkg::st_offer;
    assign o_play_card  = play_card_q;
    assign o_turn_done  = done_q;

    assign transfer    = i_card_valid && o_card_ready;
    assign take_choice = (state_q == uno_turn_pkg::st_select) && i_choice.found;

    assign o_add         = transfer && (i_card.value <= max_value);  // code 15 names no card
    assign o_remove      = take_choice;
    assign o_remove_card = i_choice.remove;

    always_comb begin
        state_d    = state_q;
        reason_d   = reason_q;
        draw_cnt_d = draw_cnt_q;
        done_d     = 1'b0;
        case (state_q)
            uno_turn_pkg::st_idle: begin
                if (i_start) begin
                    reason_d = uno_turn_pkg::reason_penalty;
                    if (i_draw_two) begin
                        state_d    = uno_turn_pkg::st_draw;
                        draw_cnt_d = cnt_two;
                    end else if (i_draw_four) begin
                        state_d    = uno_turn_pkg::st_draw;
                        draw_cnt_d = cnt_four;
                    end else begin
                        state_d = uno_turn_pkg::st_select;
                    end
                end else if (i_init) begin
                    state_d    = uno_turn_pkg::st_draw;
                    reason_d   = uno_turn_pkg::reason_deal;
                    draw_cnt_d = cnt_init;
                end
            end
            uno_turn_pkg::st_draw: begin
                if (transfer) begin
                    draw_cnt_d = draw_cnt_q - 1'b1;
                    if (draw_cnt_q == 1) begin
                        // the store takes the last card on this same edge
                        state_d = (reason_q == uno_turn_pkg::reason_penalty) ?
                                  uno_turn_pkg::st_select : uno_turn_pkg::st_idle;
                    end
                end
            end
            uno_turn_pkg::st_select: begin
                state_d = i_choice.found ? uno_turn_pkg::st_offer : uno_turn_pkg::st_no_card;
            end
            uno_turn_pkg::st_offer: begin
                if (i_play_ready) begin
                    state_d = uno_turn_pkg::st_idle;
                    done_d  = 1'b1;
                end
            end
            uno_turn_pkg::st_no_card: begin
                if (transfer) begin  // drawn card stays in the hand
                    state_d = uno_turn_pkg::st_idle;
                    done_d  = 1'b1;
                end
            end
            default: state_d = uno_turn_pkg::st_idle;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= uno_turn_pkg::st_idle;
            reason_q   <= uno_turn_pkg::reason_deal;
            draw_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            reason_q   <= reason_d;
            draw_cnt_q <= draw_cnt_d;
            done_q     <= done_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_choice) begin
            play_card_q <= i_choice.card;  // held through back-pressure
        end
    end

endmodule

// File: rtl/uno_turn_pkg.sv
package uno_turn_pkg;

    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_draw    = 3'd1,
        st_select  = 3'd2,
        st_offer   = 3'd3,
        st_no_card = 3'd4
    } uno_turn_state_e;

    // where a draw run goes when it finishes
    typedef enum logic {
        reason_deal    = 1'b0,  // back to idle
        reason_penalty = 1'b1   // straight on to select
    } uno_draw_reason_e;

endpackage
